//--- Bender.yml
package:
  name: uart

sources:
  - hw/uart_pkg.sv
  - hw/baud_gen.sv
  - hw/sync_fifo.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart_top.sv
  - target: simulation
    files:
      - verif/uart_properties.sv
      - verif/uart_tb.sv

//--- hw/baud_gen.sv
/*
 * Bit tick and 8x oversample tick from the system clock.
 * Two signed phase accumulators, each tick is the inverted sign bit.
 * Free running after reset, ticks are one-cycle enables.
 */
module baud_gen
#(
    parameter int CLK_HZ = 1_600_000,
    parameter int BAUD   = 100_000
)
(
    input  logic clk,
    input  logic reset,
    output logic bit_tick,
    output logic os_tick
);
    import uart_pkg::*;

    localparam int ACC_W   = $clog2(CLK_HZ) + 2;  // magnitude of CLK_HZ plus sign
    localparam int OS_RATE = BAUD * OVERSAMPLE;

    // step while waiting and step on a tick
    localparam logic signed [ACC_W-1:0] BIT_UP = ACC_W'(BAUD);
    localparam logic signed [ACC_W-1:0] BIT_DN = ACC_W'(BAUD - CLK_HZ);
    localparam logic signed [ACC_W-1:0] OS_UP  = ACC_W'(OS_RATE);
    localparam logic signed [ACC_W-1:0] OS_DN  = ACC_W'(OS_RATE - CLK_HZ);

    logic signed [ACC_W-1:0] bit_acc;  // bit rate phase
    logic signed [ACC_W-1:0] os_acc;   // oversample phase

    assign bit_tick = ~bit_acc[ACC_W-1];  // non-negative phase means tick
    assign os_tick  = ~os_acc[ACC_W-1];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            bit_acc <= '0;
            os_acc  <= '0;
        end
        else
        begin
            // a tick pays back CLK_HZ, so the mean rate is exact
            bit_acc <= bit_acc + (bit_tick ? BIT_DN : BIT_UP);
            os_acc  <= os_acc + (os_tick ? OS_DN : OS_UP);
        end
    end

endmodule

//--- hw/sync_fifo.sv
/*
 * Single-clock FIFO with a type parameter for the payload.
 * The head is a combinational read, a pushed word shows there next cycle.
 * DEPTH is a power of two, at least 2. Push on full and pop on empty are ignored.
 */
module sync_fifo
#(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int AW = $clog2(DEPTH);  // address bits, pointers carry one more

    payload_t     mem [DEPTH];
    logic [AW:0]  wr_ptr;               // msb is the wrap bit
    logic [AW:0]  rd_ptr;
    logic         do_push;
    logic         do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // same slot, wrap bits tell the two cases apart
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) &&
                   (wr_ptr[AW] != rd_ptr[AW]);

    assign head = mem[rd_ptr[AW-1:0]];  // first-word fall through

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

//--- hw/uart_pkg.sv
/*
 * Shared widths, frame constants and payload structs of the byte UART.
 * The RTL imports it by wildcard in module bodies and names its types
 * with the package scope in port lists. The testbench uses the same types.
 */
package uart_pkg;

    // frame shape, 8N1
    localparam int DATA_BITS    = 8;                  // data bits per frame
    localparam int OVERSAMPLE   = 8;                  // rx ticks per bit
    localparam int SAMPLE_POINT = 3;                  // tick index where rx samples
    localparam int FRAME_BITS   = 1 + DATA_BITS + 1;  // start + data + stop

    // one data byte on the line
    typedef logic [DATA_BITS-1:0] byte_t;

    // received byte, tagged with the stop bit check
    typedef struct packed
    {
        logic  frame_err;  // stop bit sampled low
        byte_t data;
    } rx_byte_t;

    // host write into the tx fifo
    typedef struct packed
    {
        logic  valid;  // spends one tx credit
        byte_t data;
    } tx_req_t;

    // host read out of the rx fifo
    typedef struct packed
    {
        logic     valid;  // one cycle, only against a granted credit
        rx_byte_t payload;
    } rx_out_t;

    // status bits gathered at the top level
    typedef struct packed
    {
        logic tx_busy;  // serializer shifting a frame
        logic rx_busy;  // deserializer inside a frame
        logic overrun;  // sticky, a byte was dropped on a full rx fifo
    } uart_status_t;

endpackage

//--- hw/uart_rx.sv
/*
 * 8N1 deserializer on the oversample tick.
 * The line is synchronized, a falling edge while idle opens a frame,
 * and each bit is sampled at SAMPLE_POINT. After the stop bit the byte is
 * pushed with a registered one-cycle strobe, flagged if the stop bit was low.
 */
module uart_rx
(
    input  logic              clk,
    input  logic              reset,
    input  logic              os_tick,
    input  logic              rxd,
    output logic              push,
    output uart_pkg::rx_byte_t push_data,
    output logic              busy
);
    import uart_pkg::*;

    localparam int OS_W  = $clog2(OVERSAMPLE);
    localparam int CNT_W = $clog2(FRAME_BITS + 1);

    logic               rx_meta;    // first sync stage
    logic               rx_sync;    // second sync stage, safe to use
    logic               rx_prev;    // for edge detect
    logic [OS_W-1:0]    os_cnt;     // tick index inside the bit
    logic [CNT_W-1:0]   bit_cnt;    // bits left in the frame
    logic [DATA_BITS:0] shreg;      // data above the start bit
    logic               fall;
    logic               sample;
    logic               start_bit;
    logic               last_bit;

    assign busy      = |bit_cnt;
    assign fall      = rx_prev & ~rx_sync;
    assign sample    = busy & os_tick & (os_cnt == OS_W'(SAMPLE_POINT));
    assign start_bit = (bit_cnt == CNT_W'(FRAME_BITS));
    assign last_bit  = (bit_cnt == CNT_W'(1));  // stop bit

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;  // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            os_cnt  <= '0;
            bit_cnt <= '0;
            push    <= 1'b0;
        end
        else
        begin
            push <= sample & last_bit;  // byte lands in the fifo next edge
            if (!busy && fall)
            begin
                bit_cnt <= CNT_W'(FRAME_BITS);
                os_cnt  <= '0;
            end
            else if (busy && os_tick)
            begin
                os_cnt <= (os_cnt == OS_W'(OVERSAMPLE - 1)) ? '0 : os_cnt + 1'b1;
                if (sample && start_bit && rx_sync)
                begin
                    bit_cnt <= '0;  // start bit gone high, glitch
                end
                else if (sample)
                begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    // start and data samples shift in from the top
    always_ff @(posedge clk)
    begin
        if (sample && !last_bit)
        begin
            shreg <= {rx_sync, shreg[DATA_BITS:1]};
        end
        if (sample && last_bit)
        begin
            push_data.frame_err <= ~rx_sync;
            push_data.data      <= shreg[DATA_BITS:1];  // start bit drops off
        end
    end

endmodule

//--- hw/uart_top.sv
/*
 * Byte UART top level. Joins the baud generator, the tx FIFO and serializer,
 * and the deserializer and rx FIFO. Both host sides run on credits.
 * Status gathers the busy flags and a sticky rx overrun bit.
 */
module uart_top
#(
    parameter int CLK_HZ   = 1_600_000,
    parameter int BAUD     = 100_000,
    parameter int TX_DEPTH = 4,
    parameter int RX_DEPTH = 4
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  uart_pkg::tx_req_t     tx_req,
    output logic                  tx_credit,
    output uart_pkg::rx_out_t     rx_out,
    input  logic                  rx_credit,
    output logic                  txd,
    input  logic                  rxd,
    output uart_pkg::uart_status_t status
);
    import uart_pkg::*;

    localparam int CRED_W = 8;  // host may grant ahead of the fifo

    logic              bit_tick;
    logic              os_tick;
    logic              tx_pop;
    byte_t             tx_head;
    logic              tx_empty;
    logic              tx_full;       // watched by the tx credit checker
    logic              tx_busy;
    logic              rx_push;
    rx_byte_t          rx_push_data;
    logic              rx_pop;
    rx_byte_t          rx_head;
    logic              rx_empty;
    logic              rx_full;
    logic              rx_busy;
    logic [CRED_W-1:0] rx_credits;    // reads the host can take
    logic              rx_valid_q;
    rx_byte_t          rx_data_q;
    logic              overrun_q;

    baud_gen #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) i_baud_gen
    (
        .clk(clk), .reset(reset), .bit_tick(bit_tick), .os_tick(os_tick)
    );

    sync_fifo #(.DEPTH(TX_DEPTH), .payload_t(byte_t)) i_tx_fifo
    (
        .clk(clk), .reset(reset), .push(tx_req.valid), .push_data(tx_req.data),
        .pop(tx_pop), .head(tx_head), .empty(tx_empty), .full(tx_full)
    );

    uart_tx i_uart_tx
    (
        .clk(clk), .reset(reset), .bit_tick(bit_tick), .fifo_empty(tx_empty),
        .fifo_head(tx_head), .pop(tx_pop), .txd(txd), .busy(tx_busy)
    );

    uart_rx i_uart_rx
    (
        .clk(clk), .reset(reset), .os_tick(os_tick), .rxd(rxd),
        .push(rx_push), .push_data(rx_push_data), .busy(rx_busy)
    );

    sync_fifo #(.DEPTH(RX_DEPTH), .payload_t(rx_byte_t)) i_rx_fifo
    (
        .clk(clk), .reset(reset), .push(rx_push), .push_data(rx_push_data),
        .pop(rx_pop), .head(rx_head), .empty(rx_empty), .full(rx_full)
    );

    assign rx_pop = ~rx_empty & (rx_credits != '0);  // spend a credit per read

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tx_credit  <= 1'b0;
            rx_credits <= '0;
            rx_valid_q <= 1'b0;
            overrun_q  <= 1'b0;
        end
        else
        begin
            tx_credit  <= tx_pop;  // slot freed, hand it back
            rx_valid_q <= rx_pop;
            if (rx_push && rx_full)
            begin
                overrun_q <= 1'b1;  // byte discarded
            end
            case ({rx_credit, rx_pop})
                2'b10:   rx_credits <= (rx_credits == '1) ? rx_credits : rx_credits + 1'b1;
                2'b01:   rx_credits <= rx_credits - 1'b1;
                default: rx_credits <= rx_credits;  // none or grant and spend
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_pop)
        begin
            rx_data_q <= rx_head;
        end
    end

    assign rx_out = '{valid: rx_valid_q, payload: rx_data_q};
    assign status = '{tx_busy: tx_busy, rx_busy: rx_busy, overrun: overrun_q};

endmodule

//--- hw/uart_tx.sv
/*
 * 8N1 serializer. Pops a byte from the tx FIFO when idle and
 * shifts the framed word out LSB first, one bit per bit tick.
 * busy falls on the stop bit's tick, and txd then rests high.
 */
module uart_tx
(
    input  logic           clk,
    input  logic           reset,
    input  logic           bit_tick,
    input  logic           fifo_empty,
    input  uart_pkg::byte_t fifo_head,
    output logic           pop,
    output logic           txd,
    output logic           busy
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BITS + 1);

    logic [FRAME_BITS-1:0] shreg;    // {stop, data, start}, lsb goes out first
    logic [CNT_W-1:0]      bit_cnt;  // bits still to put on the line

    assign busy = |bit_cnt;
    assign pop  = ~busy & ~fifo_empty;  // take the head as soon as idle

    // line and frame counter
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            txd     <= 1'b1;   // idle line is mark
            bit_cnt <= '0;
        end
        else if (pop)
        begin
            bit_cnt <= CNT_W'(FRAME_BITS);  // txd holds high until first tick
        end
        else if (busy && bit_tick)
        begin
            txd     <= shreg[0];
            bit_cnt <= bit_cnt - 1'b1;  // last decrement puts the stop bit out
        end
    end

    // frame shift register
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            shreg <= {1'b1, fifo_head, 1'b0};
        end
        else if (busy && bit_tick)
        begin
            shreg <= {1'b1, shreg[FRAME_BITS-1:1]};  // fill with mark
        end
    end

endmodule

//--- list.f
hw/uart_pkg.sv
hw/baud_gen.sv
hw/sync_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
verif/uart_properties.sv
verif/uart_tb.sv

//--- verif/uart_properties.sv
/*
 * Concurrent checks bound into the UART top level.
 * Covers the idle line, rx credit use and the tx FIFO credit rule.
 */
module uart_properties
(
    input logic clk,
    input logic reset,
    input logic txd,
    input logic tx_busy,
    input logic rx_valid,
    input logic rx_credit,
    input logic tx_push,
    input logic tx_full
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failures = 0;  // read by the testbench at the end
    int          granted;       // host grants not yet answered by a read

    // host side count of rx credits, grants minus reads
    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            granted <= 0;
        end
        else
        begin
            granted <= granted + (rx_credit ? 1 : 0) - (rx_valid ? 1 : 0);
        end
    end

    // line rests at mark between frames
    idle_line_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> txd)
    else
    begin
        $error("txd low while the serializer is idle");
        failures++;
    end

    // every read answers a grant the host has made
    read_needs_credit: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> (granted > 0))
    else
    begin
        $error("rx_out.valid without a granted rx credit");
        failures++;
    end

    // host credits keep writes off a full fifo
    no_push_when_full: assert property (@(posedge clk) disable iff (reset) tx_push |-> !tx_full)
    else
    begin
        $error("tx fifo pushed while full");
        failures++;
    end

endmodule

bind uart_top uart_properties i_uart_properties
(
    .clk(clk), .reset(reset), .txd(txd), .tx_busy(tx_busy), .rx_valid(rx_out.valid),
    .rx_credit(rx_credit), .tx_push(tx_req.valid), .tx_full(tx_full)
);

//--- verif/uart_tb.sv
/*
 * Testbench for the byte UART top level. txd loops back to rxd except
 * while the testbench injects a frame itself. A stimulus table runs first,
 * then a tx credit burst and an rx back-pressure case with overrun.
 */
module uart_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import uart_pkg::*;

    localparam int CLK_HZ       = 1_600_000;
    localparam int BAUD         = 100_000;
    localparam int TX_DEPTH     = 4;
    localparam int RX_DEPTH     = 4;
    localparam int CLKS_PER_BIT = CLK_HZ / BAUD;                 // 16
    localparam int TIMEOUT      = 20 * FRAME_BITS * CLKS_PER_BIT; // cycles per wait
    localparam int N_STIM       = 8;

    typedef struct packed
    {
        byte_t data;
        logic  inject;    // drive rxd here, stop bit low
        logic  exp_ferr;
    } stim_t;

    logic         clk;
    logic         reset;
    tx_req_t      tx_req;
    logic         tx_credit;
    rx_out_t      rx_out;
    logic         rx_credit;
    logic         txd;
    logic         rxd;
    uart_status_t status;
    logic         inject_on;            // mux select, testbench owns rxd
    logic         inject_line;

    stim_t        stim_table [N_STIM];
    logic [31:0]  rng_state;
    rx_byte_t     rx_queue [$];         // every rx_out read, in order
    int           tx_credits_back = 0;  // tx_credit pulses seen
    int           rx_valids = 0;        // rx_out.valid pulses seen
    int           tx_sent;              // tx_req writes made
    int           value_errors;
    int           timeouts;

    assign rxd = inject_on ? inject_line : txd;  // loopback

    uart_top #(.CLK_HZ(CLK_HZ), .BAUD(BAUD), .TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) i_uart_top
    (
        .clk(clk), .reset(reset), .tx_req(tx_req), .tx_credit(tx_credit),
        .rx_out(rx_out), .rx_credit(rx_credit), .txd(txd), .rxd(rxd), .status(status)
    );

    always #5 clk = ~clk;  // 10 ns

    // outputs are registered, so the posedge sees last cycle's value
    always @(posedge clk)
    begin
        if (!reset && tx_credit)
        begin
            tx_credits_back <= tx_credits_back + 1;
        end
        if (!reset && rx_out.valid)
        begin
            rx_valids <= rx_valids + 1;
            rx_queue.push_back(rx_out.payload);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic byte_t random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rx(input string name, input rx_byte_t got, input rx_byte_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("** Error at %0t: %s = {ferr %b, %h}, expected {ferr %b, %h}",
                     $time, name, got.frame_err, got.data, exp.frame_err, exp.data);
        end
    endtask

    task automatic check_status(input uart_status_t got, input uart_status_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("** Error at %0t: status {tx_busy,rx_busy,overrun} = %b, expected %b",
                     $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            value_errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        int asserts;
        asserts = i_uart_top.i_uart_properties.failures;
        $display("errors: %0d value, %0d timeout, %0d assertion", value_errors, timeouts, asserts);
        if (value_errors + timeouts + asserts == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    // one write, only against a held credit
    task automatic send_byte(input byte_t b);
        int i;
        i = 0;
        while (tx_sent - tx_credits_back >= TX_DEPTH && i < TIMEOUT)
        begin
            @(negedge clk);
            i++;
        end
        if (tx_sent - tx_credits_back >= TX_DEPTH)
        begin
            timed_out("a tx credit");
        end
        else
        begin
            tx_req = '{valid: 1'b1, data: b};
            tx_sent++;
            @(negedge clk);
            tx_req = '{valid: 1'b0, data: 8'h00};
        end
    endtask

    task automatic grant_rx(input int n);
        repeat (n)
        begin
            rx_credit = 1'b1;
            @(negedge clk);
            rx_credit = 1'b0;
        end
    endtask

    task automatic wait_rx(input string what, output rx_byte_t got);
        int i;
        i = 0;
        while (rx_queue.size() == 0 && i < TIMEOUT)
        begin
            @(negedge clk);
            i++;
        end
        if (rx_queue.size() == 0)
        begin
            timed_out(what);
        end
        else
        begin
            got = rx_queue.pop_front();
        end
    endtask

    // both paths quiet and every tx credit back
    task automatic wait_idle();
        int i;
        i = 0;
        while ((status.tx_busy || status.rx_busy || tx_credits_back != tx_sent) && i < TIMEOUT)
        begin
            @(negedge clk);
            i++;
        end
        if (status.tx_busy || status.rx_busy || tx_credits_back != tx_sent)
        begin
            timed_out("both paths idle");
        end
        else
        begin
            repeat (2) @(negedge clk);  // push strobe, then fifo write
        end
    endtask

    // frame timing from the bit period, LSB first
    task automatic inject_frame(input byte_t b, input logic stop);
        logic [FRAME_BITS-1:0] frame;
        int                    k;
        frame = {stop, b, 1'b0};
        inject_on = 1'b1;
        for (k = 0; k < FRAME_BITS; k++)
        begin
            inject_line = frame[k];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        inject_line = 1'b1;
        inject_on   = 1'b0;  // back to txd, which idles high
    endtask

    task automatic fill_table();
        stim_table[0] = '{data: 8'h55, inject: 1'b0, exp_ferr: 1'b0};
        stim_table[1] = '{data: 8'ha3, inject: 1'b0, exp_ferr: 1'b0};
        stim_table[2] = '{data: 8'h00, inject: 1'b0, exp_ferr: 1'b0};
        stim_table[3] = '{data: 8'hff, inject: 1'b0, exp_ferr: 1'b0};
        stim_table[4] = '{data: 8'h3c, inject: 1'b1, exp_ferr: 1'b1};  // broken stop bit
        stim_table[5] = '{data: 8'h81, inject: 1'b0, exp_ferr: 1'b0};  // recovery after it
        stim_table[6] = '{data: random_byte(), inject: 1'b0, exp_ferr: 1'b0};
        stim_table[7] = '{data: random_byte(), inject: 1'b0, exp_ferr: 1'b0};
    endtask

    initial
    begin
        rx_byte_t got;
        rx_byte_t exp;
        byte_t    burst [RX_DEPTH+1];
        int       n;
        int       credits_before;
        int       valids_before;
        $timeformat(-9, 0, " ns", 0);  // times in error lines
        clk          = 1'b0;
        reset        = 1'b1;
        tx_req       = '{valid: 1'b0, data: 8'h00};
        rx_credit    = 1'b0;
        inject_on    = 1'b0;
        inject_line  = 1'b1;
        tx_sent      = 0;
        value_errors = 0;
        timeouts     = 0;
        rng_state    = 32'hc37f;
        fill_table();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // idle outputs out of reset
        check_bit("txd", txd, 1'b1);
        check_bit("tx_credit", tx_credit, 1'b0);
        check_bit("rx_out.valid", rx_out.valid, 1'b0);
        check_status(status, '{tx_busy: 1'b0, rx_busy: 1'b0, overrun: 1'b0});

        // table through loopback or injection, one credit each
        for (n = 0; n < N_STIM; n++)
        begin
            exp = '{frame_err: stim_table[n].exp_ferr, data: stim_table[n].data};
            grant_rx(1);
            if (stim_table[n].inject)
            begin
                inject_frame(stim_table[n].data, 1'b0);
            end
            else
            begin
                send_byte(stim_table[n].data);
            end
            wait_rx("a table byte", got);
            check_rx("rx_out.payload", got, exp);
        end

        // tx burst spending every credit at once
        wait_idle();
        credits_before = tx_credits_back;
        grant_rx(TX_DEPTH);
        for (n = 0; n < TX_DEPTH; n++)
        begin
            burst[n] = random_byte();
        end
        for (n = 0; n < TX_DEPTH; n++)
        begin
            send_byte(burst[n]);
        end
        for (n = 0; n < TX_DEPTH; n++)
        begin
            wait_rx("a burst byte", got);
            check_byte("rx_out.payload.data", got.data, burst[n]);
            check_bit("rx_out.payload.frame_err", got.frame_err, 1'b0);
        end
        wait_idle();
        check_count("tx_credit pulses", tx_credits_back - credits_before, TX_DEPTH);

        // no rx credits, one byte too many for the rx fifo
        valids_before = rx_valids;
        for (n = 0; n <= RX_DEPTH; n++)
        begin
            burst[n] = random_byte();
            send_byte(burst[n]);
        end
        wait_idle();
        check_status(status, '{tx_busy: 1'b0, rx_busy: 1'b0, overrun: 1'b1});
        check_count("rx_out.valid pulses", rx_valids - valids_before, 0);
        grant_rx(RX_DEPTH + 1);  // one spare credit
        for (n = 0; n < RX_DEPTH; n++)
        begin
            wait_rx("a buffered byte", got);
            check_rx("rx_out.payload", got, '{frame_err: 1'b0, data: burst[n]});
        end
        repeat (4 * CLKS_PER_BIT) @(negedge clk);  // room for a stray read
        check_count("rx_out.valid pulses", rx_valids - valids_before, RX_DEPTH);
        finish_run();
    end

endmodule
